// File: src/pcap_replay_pkg.sv
`default_nettype none
/* Packet capture and replay shared definitions
   Stream widths, port codes and the beat, memory word and request types */
package pcap_replay_pkg;

  localparam int DATA_WIDTH         = 64;
  localparam int KEEP_WIDTH         = 8;
  localparam int TUSER_WIDTH        = 32;
  localparam int SRC_PORT_LSB       = 16;
  localparam int MEM_ADDR_WIDTH     = 6;
  localparam int REPLAY_COUNT_WIDTH = 8;
  localparam int OUT_QUEUE_DEPTH    = 16;

  localparam logic [7:0]  CAPTURE_SRC_PORT = 8'h02;
  localparam logic [15:0] OUT_PORT_STAMP   = 16'h0102;

  typedef struct packed {
    logic [DATA_WIDTH-1:0]  tdata;
    logic [KEEP_WIDTH-1:0]  tkeep;
    logic [TUSER_WIDTH-1:0] tuser;
    logic                   tlast;
  } axis_beat_t;

  // One memory word, either a stored beat or the end-of-capture marker
  typedef union packed {
    struct packed {
      logic       end_flag;
      logic       valid;
      axis_beat_t beat;
    } as_beat;
    struct packed {
      logic                       end_flag;
      logic [$bits(axis_beat_t):0] pad;
    } as_marker;
  } mem_entry_u;

  typedef struct packed {
    logic                      en;
    logic [MEM_ADDR_WIDTH-1:0] addr;
    mem_entry_u                data;
  } mem_wr_req_t;

  typedef struct packed {
    logic                      en;
    logic [MEM_ADDR_WIDTH-1:0] addr;
  } mem_rd_req_t;

  typedef struct packed {
    logic                          soft_reset;
    logic                          capture_done;
    logic                          replay_start;
    logic [REPLAY_COUNT_WIDTH-1:0] replay_count;
  } replay_ctrl_t;

endpackage

`default_nettype wire

// File: src/pcap_capture_writer.sv
`timescale 1ns/1ps
`default_nettype none
/* Capture writer
   Keeps packets from the capture source port and writes them one beat per
   word into packet memory, closing the capture with an end marker */
module pcap_capture_writer (
  input  wire                                axis_aclk,
  input  wire                                axis_aresetn,
  input  wire pcap_replay_pkg::replay_ctrl_t ctrl,
  input  wire                                replay_busy,
  input  wire pcap_replay_pkg::axis_beat_t   s_axis_beat,
  input  wire                                s_axis_tvalid,
  output logic                               s_axis_tready,
  output pcap_replay_pkg::mem_wr_req_t       wr_req
);
  import pcap_replay_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_STORE, ST_SKIP} wr_state_t;

  wr_state_t                 state;
  logic [MEM_ADDR_WIDTH-1:0] wr_addr;
  logic                      accept;
  logic                      port_match;
  logic                      store_beat;
  logic                      wr_en_q;
  logic [MEM_ADDR_WIDTH-1:0] wr_addr_q;
  mem_entry_u                wr_data_q;

  // Input stalls while the memory is being replayed
  assign s_axis_tready = ~replay_busy;
  assign accept        = s_axis_tvalid & s_axis_tready;
  assign port_match    = (s_axis_beat.tuser[SRC_PORT_LSB +: 8] == CAPTURE_SRC_PORT);
  assign store_beat    = accept & (((state == ST_IDLE) & port_match) | (state == ST_STORE));

  always_ff @(posedge axis_aclk) begin
    if (!axis_aresetn || ctrl.soft_reset) begin
      state   <= ST_IDLE;
      wr_addr <= MEM_ADDR_WIDTH'(1);
    end else if (ctrl.capture_done) begin
      state   <= ST_IDLE;
      wr_addr <= MEM_ADDR_WIDTH'(1);
    end else begin
      if (store_beat) begin
        wr_addr <= wr_addr + 1'b1;
      end
      if (accept) begin
        case (state)
          ST_IDLE: begin
            // Single-beat packets leave the FSM in idle
            if (!s_axis_beat.tlast) begin
              state <= port_match ? ST_STORE : ST_SKIP;
            end
          end
          default: begin
            if (s_axis_beat.tlast) begin
              state <= ST_IDLE;
            end
          end
        endcase
      end
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_aresetn || ctrl.soft_reset) begin
      wr_en_q <= 1'b0;
    end else begin
      wr_en_q <= ctrl.capture_done | store_beat;
    end
  end

  always_ff @(posedge axis_aclk) begin
    wr_addr_q <= wr_addr;
    if (ctrl.capture_done) begin
      wr_data_q.as_marker.end_flag <= 1'b1;
      wr_data_q.as_marker.pad      <= '0;
    end else begin
      wr_data_q.as_beat.end_flag <= 1'b0;
      wr_data_q.as_beat.valid    <= 1'b1;
      wr_data_q.as_beat.beat     <= s_axis_beat;
    end
  end

  always_comb begin
    wr_req.en   = wr_en_q;
    wr_req.addr = wr_addr_q;
    wr_req.data = wr_data_q;
  end

  // Top word stays free so the end marker always fits
  a_no_wrap: assert property (@(posedge axis_aclk) disable iff (!axis_aresetn)
    store_beat |-> (wr_addr != {MEM_ADDR_WIDTH{1'b1}}))
    else $error("capture overruns packet memory");

endmodule

`default_nettype wire

// File: src/pcap_replay_reader.sv
`timescale 1ns/1ps
`default_nettype none
/* Replay reader
   Reads the captured beats back from address 1, loops on the end marker
   replay_count times and feeds the output queue */
module pcap_replay_reader (
  input  wire                                axis_aclk,
  input  wire                                axis_aresetn,
  input  wire pcap_replay_pkg::replay_ctrl_t ctrl,
  output pcap_replay_pkg::mem_rd_req_t       rd_req,
  input  wire                                rd_ack,
  input  wire pcap_replay_pkg::mem_entry_u   rd_data,
  input  wire                                nearly_full,
  output logic                               push,
  output pcap_replay_pkg::axis_beat_t        push_beat,
  output logic                               replay_busy
);
  import pcap_replay_pkg::*;

  typedef enum logic {ST_IDLE, ST_RUN} rd_state_t;

  rd_state_t                     state;
  logic                          start_d;
  logic                          start_pulse;
  logic [MEM_ADDR_WIDTH-1:0]     rd_addr;
  logic [REPLAY_COUNT_WIDTH-1:0] loop_cnt;
  logic [REPLAY_COUNT_WIDTH-1:0] loop_total;
  logic                          rd_pending;
  logic                          discard;
  logic                          word_live;
  logic                          marker_hit;

  // Start is a level, only its rising edge counts
  always_ff @(posedge axis_aclk) begin
    if (!axis_aresetn) begin
      start_d <= 1'b0;
    end else begin
      start_d <= ctrl.replay_start;
    end
  end

  assign start_pulse = ctrl.replay_start & ~start_d;

  // Returned word, minus the one read past an end marker
  assign word_live  = rd_pending & ~discard;
  assign marker_hit = word_live & rd_data.as_marker.end_flag;

  always_comb begin
    rd_req.en   = (state == ST_RUN) & ~nearly_full;
    rd_req.addr = rd_addr;
  end

  assign push        = word_live & ~rd_data.as_beat.end_flag & rd_data.as_beat.valid;
  assign push_beat   = rd_data.as_beat.beat;
  assign replay_busy = (state == ST_RUN);

  always_ff @(posedge axis_aclk) begin
    if (!axis_aresetn || ctrl.soft_reset) begin
      state      <= ST_IDLE;
      rd_addr    <= MEM_ADDR_WIDTH'(1);
      loop_cnt   <= '0;
      loop_total <= '0;
      rd_pending <= 1'b0;
      discard    <= 1'b0;
    end else begin
      rd_pending <= rd_ack;
      discard    <= marker_hit;
      case (state)
        ST_IDLE: begin
          // Zero count means no replay at all
          if (start_pulse && ctrl.replay_count != '0) begin
            state      <= ST_RUN;
            rd_addr    <= MEM_ADDR_WIDTH'(1);
            loop_cnt   <= '0;
            loop_total <= ctrl.replay_count;
          end
        end
        ST_RUN: begin
          if (marker_hit) begin
            rd_addr <= MEM_ADDR_WIDTH'(1);
            if (loop_cnt == loop_total - 1'b1) begin
              state <= ST_IDLE;
            end else begin
              loop_cnt <= loop_cnt + 1'b1;
            end
          end else if (rd_ack) begin
            rd_addr <= rd_addr + 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Address 0 holds nothing, a read there means a capture with no marker
  a_no_addr0: assert property (@(posedge axis_aclk) disable iff (!axis_aresetn)
    rd_req.en |-> (rd_req.addr != '0))
    else $error("replay read of address 0");

endmodule

`default_nettype wire

// File: src/pcap_mem_port.sv
`timescale 1ns/1ps
`default_nettype none
/* Packet memory
   Single-port storage, one access per cycle, a write always beats a read */
module pcap_mem_port (
  input  wire                               axis_aclk,
  input  wire pcap_replay_pkg::mem_wr_req_t wr_req,
  input  wire pcap_replay_pkg::mem_rd_req_t rd_req,
  output logic                              rd_ack,
  output pcap_replay_pkg::mem_entry_u       rd_data
);
  import pcap_replay_pkg::*;

  mem_entry_u                mem [2**MEM_ADDR_WIDTH];
  logic [MEM_ADDR_WIDTH-1:0] port_addr;

  // One address bus shared by both sides
  assign rd_ack    = rd_req.en & ~wr_req.en;
  assign port_addr = wr_req.en ? wr_req.addr : rd_req.addr;

  always_ff @(posedge axis_aclk) begin
    if (wr_req.en) begin
      mem[port_addr] <= wr_req.data;
    end
  end

  // Registered read data
  always_ff @(posedge axis_aclk) begin
    if (rd_ack) begin
      rd_data <= mem[port_addr];
    end
  end

endmodule

`default_nettype wire

// File: src/replay_out_queue.sv
`timescale 1ns/1ps
`default_nettype none
/* Replay output queue
   Fall-through beat FIFO with nearly-full throttle, stamps tuser on output */
module replay_out_queue (
  input  wire                                axis_aclk,
  input  wire                                axis_aresetn,
  input  wire pcap_replay_pkg::replay_ctrl_t ctrl,
  input  wire                                push,
  input  wire pcap_replay_pkg::axis_beat_t   push_beat,
  output logic                               nearly_full,
  output pcap_replay_pkg::axis_beat_t        m_axis_beat,
  output logic                               m_axis_tvalid,
  input  wire                                m_axis_tready
);
  import pcap_replay_pkg::*;

  axis_beat_t                           slots [OUT_QUEUE_DEPTH];
  logic [$clog2(OUT_QUEUE_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(OUT_QUEUE_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(OUT_QUEUE_DEPTH):0]     count;
  logic                                 pop;

  assign m_axis_tvalid = (count != '0);
  assign pop           = m_axis_tvalid & m_axis_tready;
  // Two slots of slack for the read in flight
  assign nearly_full   = (count >= OUT_QUEUE_DEPTH - 2);

  always_comb begin
    m_axis_beat       = slots[rd_ptr];
    m_axis_beat.tuser = {OUT_PORT_STAMP, {(TUSER_WIDTH-16){1'b0}}};
  end

  always_ff @(posedge axis_aclk) begin
    if (push) begin
      slots[wr_ptr] <= push_beat;
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_aresetn || ctrl.soft_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Reader throttling must keep the queue from overflowing
  a_no_overflow: assert property (@(posedge axis_aclk) disable iff (!axis_aresetn)
    push |-> (count != OUT_QUEUE_DEPTH))
    else $error("push into full output queue");

endmodule

`default_nettype wire

// File: src/pcap_replay_top.sv
`timescale 1ns/1ps
`default_nettype none
/* Packet capture and replay engine
   Capture writer and replay reader sharing one packet memory */
module pcap_replay_top (
  input  wire                                axis_aclk,
  input  wire                                axis_aresetn,
  input  wire pcap_replay_pkg::replay_ctrl_t ctrl,
  input  wire pcap_replay_pkg::axis_beat_t   s_axis_beat,
  input  wire                                s_axis_tvalid,
  output logic                               s_axis_tready,
  output pcap_replay_pkg::axis_beat_t        m_axis_beat,
  output logic                               m_axis_tvalid,
  input  wire                                m_axis_tready,
  output logic                               replay_busy
);
  import pcap_replay_pkg::*;

  mem_wr_req_t wr_req;
  mem_rd_req_t rd_req;
  logic        rd_ack;
  mem_entry_u  rd_data;
  logic        push;
  axis_beat_t  push_beat;
  logic        nearly_full;

  pcap_capture_writer u_writer (
    .axis_aclk     (axis_aclk),
    .axis_aresetn  (axis_aresetn),
    .ctrl          (ctrl),
    .replay_busy   (replay_busy),
    .s_axis_beat   (s_axis_beat),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .wr_req        (wr_req)
  );

  pcap_replay_reader u_reader (
    .axis_aclk    (axis_aclk),
    .axis_aresetn (axis_aresetn),
    .ctrl         (ctrl),
    .rd_req       (rd_req),
    .rd_ack       (rd_ack),
    .rd_data      (rd_data),
    .nearly_full  (nearly_full),
    .push         (push),
    .push_beat    (push_beat),
    .replay_busy  (replay_busy)
  );

  pcap_mem_port u_mem (
    .axis_aclk (axis_aclk),
    .wr_req    (wr_req),
    .rd_req    (rd_req),
    .rd_ack    (rd_ack),
    .rd_data   (rd_data)
  );

  replay_out_queue u_out_queue (
    .axis_aclk     (axis_aclk),
    .axis_aresetn  (axis_aresetn),
    .ctrl          (ctrl),
    .push          (push),
    .push_beat     (push_beat),
    .nearly_full   (nearly_full),
    .m_axis_beat   (m_axis_beat),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready)
  );

endmodule

`default_nettype wire

// File: bench/tb_pcap_replay.sv
`timescale 1ns/1ps
`default_nettype none
/* Testbench for the packet capture and replay engine
   Random mixed-port capture, looped replay under sink stalls, checked
   beat by beat against a model queue */
module tb_pcap_replay;
  import pcap_replay_pkg::*;

  logic         axis_aclk;
  logic         axis_aresetn;
  replay_ctrl_t ctrl;
  axis_beat_t   s_axis_beat;
  logic         s_axis_tvalid;
  logic         s_axis_tready;
  axis_beat_t   m_axis_beat;
  logic         m_axis_tvalid;
  logic         m_axis_tready;
  logic         replay_busy;

  integer       seed;
  integer       ready_seed;
  int           cycle_count = 0;
  int           cycle_limit;
  int           checks;
  int           mismatches;
  int           other_errors;
  logic         bp_on;
  axis_beat_t   cap_q[$];
  axis_beat_t   exp_q[$];

  pcap_replay_top DUT (
    .axis_aclk     (axis_aclk),
    .axis_aresetn  (axis_aresetn),
    .ctrl          (ctrl),
    .s_axis_beat   (s_axis_beat),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .m_axis_beat   (m_axis_beat),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .replay_busy   (replay_busy)
  );

  always #2 axis_aclk = ~axis_aclk;

  task automatic check(input logic [63:0] got, input logic [63:0] want, input string what);
    checks++;
    if (got !== want) begin
      mismatches++;
      $display("MISMATCH at %0t ns: %s got %0h expected %0h", $time, what, got, want);
    end
  endtask

  // Sink stalls roughly one cycle in three
  always @(posedge axis_aclk) begin
    if (bp_on) begin
      m_axis_tready <= (({$random(ready_seed)} % 3) != 0);
    end else begin
      m_axis_tready <= 1'b1;
    end
  end

  always @(posedge axis_aclk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("ERROR: run stopped, no progress after %0d cycles", cycle_count);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // Output beats transfer on the next rising edge
  always @(negedge axis_aclk) begin
    axis_beat_t want;
    if (axis_aresetn) begin
      if (replay_busy) begin
        check(64'(s_axis_tready), 64'd0, "s_axis_tready during replay");
      end
      if (m_axis_tvalid && m_axis_tready) begin
        if (exp_q.size() == 0) begin
          other_errors++;
          $display("ERROR at %0t ns: output beat with nothing left to replay", $time);
        end else begin
          want = exp_q.pop_front();
          check(m_axis_beat.tdata, want.tdata, "tdata");
          check(64'(m_axis_beat.tkeep), 64'(want.tkeep), "tkeep");
          check(64'(m_axis_beat.tuser), 64'(want.tuser), "tuser");
          check(64'(m_axis_beat.tlast), 64'(want.tlast), "tlast");
        end
      end
    end
  end

  task automatic idle(input int n);
    cycle_limit += n;
    repeat (n) @(posedge axis_aclk);
  endtask

  task automatic pulse_ctrl(input replay_ctrl_t c);
    cycle_limit += 2;
    @(posedge axis_aclk);
    ctrl <= c;
    @(posedge axis_aclk);
    ctrl <= '0;
  endtask

  task automatic send_packet(input int len, input logic [7:0] port);
    axis_beat_t b;
    cycle_limit += 8 * len;
    for (int i = 0; i < len; i++) begin
      b.tdata = {$random(seed), $random(seed)};
      b.tkeep = 8'($random(seed));
      b.tuser = {8'($random(seed)), port, 16'($random(seed))};
      b.tlast = (i == len - 1);
      if (port == 8'h02) begin
        cap_q.push_back(b);
      end
      @(posedge axis_aclk);
      s_axis_beat   <= b;
      s_axis_tvalid <= 1'b1;
      do @(negedge axis_aclk); while (!s_axis_tready);
    end
    @(posedge axis_aclk);
    s_axis_tvalid <= 1'b0;
  endtask

  // At most 48 stored beats, so the marker always fits
  task automatic capture(input int npkts);
    replay_ctrl_t c;
    logic [7:0]   port;
    for (int p = 0; p < npkts; p++) begin
      port = 8'($random(seed));
      if (p == 0 || port[7]) begin
        port = 8'h02;
      end else if (port == 8'h02) begin
        port = 8'h05;
      end
      send_packet(1 + ({$random(seed)} % 4), port);
    end
    idle(3);
    c = '0;
    c.capture_done = 1'b1;
    pulse_ctrl(c);
    idle(3);
  endtask

  task automatic replay(input int count);
    replay_ctrl_t c;
    axis_beat_t   b;
    c = '0;
    c.replay_start = 1'b1;
    c.replay_count = 8'(count);
    for (int k = 0; k < count; k++) begin
      foreach (cap_q[i]) begin
        b = cap_q[i];
        b.tuser = 32'h0102_0000;
        exp_q.push_back(b);
      end
    end
    cycle_limit += 8 * exp_q.size();
    pulse_ctrl(c);
    do @(negedge axis_aclk); while (exp_q.size() != 0 || replay_busy);
  endtask

  initial begin
    replay_ctrl_t c;
    seed          = 32'h1a97_f672;
    ready_seed    = seed ^ 32'h0f0f_0f0f;
    axis_aclk     = 1'b0;
    axis_aresetn  = 1'b0;
    ctrl          = '0;
    s_axis_beat   = '0;
    s_axis_tvalid = 1'b0;
    m_axis_tready = 1'b1;
    bp_on         = 1'b0;
    cycle_limit   = 516;
    checks        = 0;
    mismatches    = 0;
    other_errors  = 0;
    repeat (16) @(posedge axis_aclk);
    axis_aresetn <= 1'b1;
    @(negedge axis_aclk);
    check(64'(m_axis_tvalid), 64'd0, "m_axis_tvalid after reset");
    check(64'(replay_busy), 64'd0, "replay_busy after reset");
    check(64'(s_axis_tready), 64'd1, "s_axis_tready after reset");

    capture(12);
    bp_on <= 1'b1;
    replay(1 + ({$random(seed)} % 3));
    bp_on <= 1'b0;
    replay(1 + ({$random(seed)} % 3));

    // Zero count must not start anything
    c = '0;
    c.replay_start = 1'b1;
    pulse_ctrl(c);
    cycle_limit += 100;
    repeat (100) begin
      @(negedge axis_aclk);
      check(64'(m_axis_tvalid), 64'd0, "m_axis_tvalid after zero-count start");
      check(64'(replay_busy), 64'd0, "replay_busy after zero-count start");
    end

    // Half-finished capture, dropped by soft reset
    send_packet(3, 8'h02);
    send_packet(2, 8'h02);
    idle(3);
    c = '0;
    c.soft_reset = 1'b1;
    pulse_ctrl(c);
    cap_q.delete();
    capture(6);
    bp_on <= 1'b1;
    replay(1 + ({$random(seed)} % 3));
    idle(10);

    $display("Run complete: %0d checks, %0d mismatches, %0d other errors",
             checks, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
src/pcap_replay_pkg.sv
src/pcap_capture_writer.sv
src/pcap_replay_reader.sv
src/pcap_mem_port.sv
src/replay_out_queue.sv
src/pcap_replay_top.sv
bench/tb_pcap_replay.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the capture and replay testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_pcap_replay -f list.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "Simulation reported errors, see sim.log"
  exit 1
fi
